//--- rtl/swc_pkg.sv
`default_nettype none

package swc_pkg;

	localparam int NUM_PORTS      = 4;
	localparam int BEATS_PER_CELL = 4;
	localparam int BEAT_IDX_W     = $clog2(BEATS_PER_CELL);
	localparam int CELL_AW        = 7;                       // 128 cells
	localparam int REF_W          = $clog2(NUM_PORTS + 1);  // copies per cell, 0..4
	localparam int MAX_DATA_W     = 128;                     // beat width on the output side

	// frame descriptor, ahead of its data beats
	typedef struct packed {
		logic [NUM_PORTS-1:0] port_map;   // never zero
		logic [5:0]           cell_count; // 1 to 63
	} swc_desc_t;

	// port queue entry
	typedef struct packed {
		logic [CELL_AW-1:0] addr;
		logic               first; // first cell of frame
		logic               last;  // last cell of frame
	} swc_cell_ptr_t;

	typedef struct packed {
		logic [MAX_DATA_W-1:0] data;
		logic                  first; // first beat of first cell
		logic                  last;  // last beat of last cell
	} swc_out_beat_t;

endpackage

`default_nettype wire

//--- rtl/swc_sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module swc_sync_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 8
) (
	input  wire                          clk,
	input  wire                          rstn,
	input  wire                          i_push,
	input  wire payload_t                i_data,
	input  wire                          i_pop,
	output payload_t                     o_data,
	output logic                         o_empty,
	output logic [$clog2(DEPTH+1)-1:0]  o_count
);

	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	payload_t      mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;

	always_ff @(posedge clk) begin
		if (i_push)
			mem[wr_ptr] <= i_data;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			o_count <= '0;
		end else begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1;
			o_count <= o_count + CW'(i_push) - CW'(i_pop);
		end
	end

	assign o_data  = mem[rd_ptr]; // fall through
	assign o_empty = (o_count == '0);

endmodule

`default_nettype wire

//--- rtl/swc_free_queue.sv
`timescale 1ns/100ps
`default_nettype none

module swc_free_queue (
	input  wire                          clk,
	input  wire                          rstn,
	input  wire                          i_pop,
	input  wire                          i_push,
	input  wire [swc_pkg::CELL_AW-1:0]   i_push_addr,
	output logic [swc_pkg::CELL_AW-1:0]  o_head_addr,
	output logic [swc_pkg::CELL_AW:0]    o_count,
	output logic                         o_ready
);

	localparam int AW    = swc_pkg::CELL_AW;
	localparam int CELLS = 2 ** AW;

	logic [AW-1:0] mem [CELLS];
	logic [AW-1:0] head;
	logic [AW-1:0] tail;
	logic [AW-1:0] init_cnt;
	logic          init_done;

	always_ff @(posedge clk) begin
		if (!init_done)
			mem[init_cnt] <= init_cnt; // load every address once
		else if (i_push)
			mem[tail] <= i_push_addr;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			head      <= '0;
			tail      <= '0;
			init_cnt  <= '0;
			init_done <= 1'b0;
			o_count   <= '0;
		end else if (!init_done) begin
			init_cnt <= init_cnt + 1'b1;
			o_count  <= o_count + 1'b1;
			if (init_cnt == '1)
				init_done <= 1'b1; // tail wrapped back to 0, list full
		end else begin
			if (i_pop)
				head <= head + 1'b1;
			if (i_push)
				tail <= tail + 1'b1;
			o_count <= o_count + (AW+1)'(i_push) - (AW+1)'(i_pop);
		end
	end

	assign o_head_addr = mem[head];
	assign o_ready     = init_done;

endmodule

`default_nettype wire

//--- rtl/swc_cell_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module swc_cell_buffer #(
	parameter int DATA_W = 128
) (
	input  wire                                                clk,
	input  wire                                                rstn,
	input  wire                                                i_alloc_req,
	output logic [swc_pkg::CELL_AW-1:0]                        o_alloc_addr,
	output logic [swc_pkg::CELL_AW:0]                          o_free_count,
	output logic                                               o_fq_ready,
	input  wire                                                i_wr_en,
	input  wire [swc_pkg::CELL_AW+swc_pkg::BEAT_IDX_W-1:0]     i_wr_addr,
	input  wire [DATA_W-1:0]                                   i_wr_data,
	input  wire                                                i_ref_wr,
	input  wire [swc_pkg::REF_W-1:0]                           i_ref_count,
	input  wire                                                i_rd_en,
	input  wire [swc_pkg::CELL_AW+swc_pkg::BEAT_IDX_W-1:0]     i_rd_addr,
	output logic [DATA_W-1:0]                                  o_rd_data,
	input  wire                                                i_release,
	input  wire [swc_pkg::CELL_AW-1:0]                         i_release_addr
);

	localparam int BW    = swc_pkg::BEAT_IDX_W;
	localparam int AW    = swc_pkg::CELL_AW + BW;
	localparam int RW    = swc_pkg::REF_W;
	localparam int CELLS = 2 ** swc_pkg::CELL_AW;

	logic [DATA_W-1:0]          data_ram [CELLS * swc_pkg::BEATS_PER_CELL];
	logic [RW-1:0]              ref_ram [CELLS];
	logic [RW-1:0]              ref_now;
	logic                       ref_last;
	logic [swc_pkg::CELL_AW-1:0] ref_wr_cell;

	//==========================================================================
	// cell data, one write and one registered read port
	//==========================================================================
	always_ff @(posedge clk) begin
		if (i_wr_en)
			data_ram[i_wr_addr] <= i_wr_data;
		if (i_rd_en)
			o_rd_data <= data_ram[i_rd_addr];
	end

	//==========================================================================
	// multicast reference counts
	//==========================================================================
	assign ref_wr_cell = i_wr_addr[AW-1:BW]; // counted on the cell's first beat
	assign ref_now     = ref_ram[i_release_addr];
	assign ref_last    = i_release && (ref_now == RW'(1)); // last copy gone

	always_ff @(posedge clk) begin
		if (i_ref_wr)
			ref_ram[ref_wr_cell] <= i_ref_count;
		if (i_release && !ref_last)
			ref_ram[i_release_addr] <= ref_now - 1'b1;
	end

	swc_free_queue u_free_queue (
		.clk        (clk),
		.rstn       (rstn),
		.i_pop      (i_alloc_req),
		.i_push     (ref_last),
		.i_push_addr(i_release_addr),
		.o_head_addr(o_alloc_addr),
		.o_count    (o_free_count),
		.o_ready    (o_fq_ready)
	);

endmodule

`default_nettype wire

//--- rtl/swc_ingress_writer.sv
`timescale 1ns/100ps
`default_nettype none

module swc_ingress_writer #(
	parameter int DATA_W        = 128,
	parameter int IN_FIFO_BEATS = 64
) (
	input  wire                                                clk,
	input  wire                                                rstn,
	input  wire                                                i_desc_valid,
	input  wire swc_pkg::swc_desc_t                            i_desc,
	input  wire                                                i_beat_valid,
	input  wire [DATA_W-1:0]                                   i_beat_data,
	output logic                                               o_in_credit,
	output logic                                               o_desc_credit,
	output logic                                               o_alloc_req,
	input  wire [swc_pkg::CELL_AW-1:0]                         i_alloc_addr,
	input  wire [swc_pkg::CELL_AW:0]                           i_free_count,
	input  wire                                                i_fq_ready,
	output logic                                               o_wr_en,
	output logic [swc_pkg::CELL_AW+swc_pkg::BEAT_IDX_W-1:0]    o_wr_addr,
	output logic [DATA_W-1:0]                                  o_wr_data,
	output logic                                               o_ref_wr,
	output logic [swc_pkg::REF_W-1:0]                          o_ref_count,
	output logic [swc_pkg::NUM_PORTS-1:0]                      o_enq,
	output swc_pkg::swc_cell_ptr_t                             o_enq_ptr,
	input  wire                                                i_enq_block
);

	localparam int FCW        = swc_pkg::CELL_AW + 1;
	localparam int DESC_DEPTH = 8;

	typedef enum logic [1:0] {S_IDLE, S_ALLOC, S_WRITE} state_t;

	state_t                          state;
	swc_pkg::swc_desc_t              desc_head;
	logic [DATA_W-1:0]               beat_head;
	logic                            desc_empty;
	logic                            beat_empty;
	logic                            desc_pop;
	logic                            beat_pop;
	logic                            last_beat;
	logic [swc_pkg::NUM_PORTS-1:0]   port_map;
	logic [5:0]                      cells_left;
	logic                            first_cell;
	logic [swc_pkg::CELL_AW-1:0]     cell_addr;
	logic [swc_pkg::BEAT_IDX_W-1:0]  beat_idx;

	swc_sync_fifo #(.payload_t(logic [DATA_W-1:0]), .DEPTH(IN_FIFO_BEATS)) u_beat_fifo (
		.clk    (clk),
		.rstn   (rstn),
		.i_push (i_beat_valid),
		.i_data (i_beat_data),
		.i_pop  (beat_pop),
		.o_data (beat_head),
		.o_empty(beat_empty),
		.o_count()
	);

	swc_sync_fifo #(.payload_t(swc_pkg::swc_desc_t), .DEPTH(DESC_DEPTH)) u_desc_fifo (
		.clk    (clk),
		.rstn   (rstn),
		.i_push (i_desc_valid),
		.i_data (i_desc),
		.i_pop  (desc_pop),
		.o_data (desc_head),
		.o_empty(desc_empty),
		.o_count()
	);

	// whole frame must fit before the first cell is taken
	assign desc_pop  = (state == S_IDLE) && i_fq_ready && !desc_empty &&
	                   (i_free_count >= FCW'(desc_head.cell_count));
	assign last_beat = (beat_idx == '1);
	assign beat_pop  = (state == S_WRITE) && !beat_empty && !(last_beat && i_enq_block);

	assign o_in_credit   = beat_pop;
	assign o_desc_credit = desc_pop;
	assign o_alloc_req   = (state == S_ALLOC);
	assign o_wr_en       = beat_pop;
	assign o_wr_addr     = {cell_addr, beat_idx};
	assign o_wr_data     = beat_head;
	assign o_ref_wr      = beat_pop && (beat_idx == '0);
	assign o_ref_count   = swc_pkg::REF_W'($countones(port_map));
	assign o_enq         = (beat_pop && last_beat) ? port_map : '0;
	assign o_enq_ptr     = '{addr: cell_addr, first: first_cell, last: (cells_left == 6'd1)};

	always_ff @(posedge clk) begin
		if (state == S_ALLOC)
			cell_addr <= i_alloc_addr; // head of the free queue
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state      <= S_IDLE;
			port_map   <= '0;
			cells_left <= '0;
			first_cell <= 1'b0;
			beat_idx   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (desc_pop) begin
						port_map   <= desc_head.port_map;
						cells_left <= desc_head.cell_count;
						first_cell <= 1'b1;
						state      <= S_ALLOC;
					end
				end
				S_ALLOC: begin
					beat_idx <= '0;
					state    <= S_WRITE;
				end
				S_WRITE: begin
					if (beat_pop) begin // waits here for missing beats
						beat_idx <= beat_idx + 1'b1;
						if (last_beat) begin
							first_cell <= 1'b0;
							cells_left <= cells_left - 1'b1;
							state      <= (cells_left == 6'd1) ? S_IDLE : S_ALLOC;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/swc_egress_scheduler.sv
`timescale 1ns/100ps
`default_nettype none

module swc_egress_scheduler #(
	parameter int OUT_CREDITS = 8
) (
	input  wire                                                clk,
	input  wire                                                rstn,
	input  wire [swc_pkg::NUM_PORTS-1:0]                       i_enq,
	input  wire swc_pkg::swc_cell_ptr_t                        i_enq_ptr,
	output logic                                               o_enq_block,
	output logic                                               o_rd_en,
	output logic [swc_pkg::CELL_AW+swc_pkg::BEAT_IDX_W-1:0]    o_rd_addr,
	input  wire [swc_pkg::MAX_DATA_W-1:0]                      i_rd_data,
	output logic                                               o_release,
	output logic [swc_pkg::CELL_AW-1:0]                        o_release_addr,
	output logic                                               o_out_valid,
	output logic [swc_pkg::NUM_PORTS-1:0]                      o_out_port,
	output swc_pkg::swc_out_beat_t                             o_out_beat,
	input  wire [swc_pkg::NUM_PORTS-1:0]                       i_out_credit
);

	localparam int NP           = swc_pkg::NUM_PORTS;
	localparam int PW           = $clog2(NP);
	localparam int Q_DEPTH      = 16;
	localparam int QCW          = $clog2(Q_DEPTH + 1);
	localparam int CW           = $clog2(OUT_CREDITS + 1);
	localparam int CELL_CREDITS = swc_pkg::BEATS_PER_CELL;

	swc_pkg::swc_cell_ptr_t          q_head [NP];
	logic [QCW-1:0]                  q_count [NP];
	logic [NP-1:0]                   q_empty;
	logic [NP-1:0]                   q_pop;
	logic [NP-1:0]                   q_nearly_full;
	logic [NP-1:0]                   ready;
	logic [NP-1:0][CW-1:0]           credit;
	logic                            gnt_valid;
	logic [PW-1:0]                   gnt_port;
	logic [PW-1:0]                   rr_ptr;
	logic                            rd_busy;
	logic [swc_pkg::BEAT_IDX_W-1:0]  rd_idx;
	logic [swc_pkg::CELL_AW-1:0]     rd_cell;
	logic [NP-1:0]                   rd_port;
	logic                            rd_first;
	logic                            rd_last;
	logic                            out_first;
	logic                            out_last;

	//==========================================================================
	// port queues
	//==========================================================================
	for (genvar p = 0; p < NP; p++) begin : g_port
		swc_sync_fifo #(.payload_t(swc_pkg::swc_cell_ptr_t), .DEPTH(Q_DEPTH)) u_queue (
			.clk    (clk),
			.rstn   (rstn),
			.i_push (i_enq[p]),
			.i_data (i_enq_ptr),
			.i_pop  (q_pop[p]),
			.o_data (q_head[p]),
			.o_empty(q_empty[p]),
			.o_count(q_count[p])
		);

		assign q_nearly_full[p] = (q_count[p] >= QCW'(Q_DEPTH - 1));
		assign ready[p]         = !q_empty[p] && (credit[p] >= CW'(CELL_CREDITS));
		assign q_pop[p]         = gnt_valid && (gnt_port == PW'(p));
	end

	assign o_enq_block = |q_nearly_full; // fewer than two free entries somewhere

	// a whole cell is charged at grant
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			for (int p = 0; p < NP; p++)
				credit[p] <= CW'(OUT_CREDITS);
		end else begin
			for (int p = 0; p < NP; p++)
				credit[p] <= credit[p] + CW'(i_out_credit[p]) -
				             CW'(q_pop[p] ? CELL_CREDITS : 0);
		end
	end

	//==========================================================================
	// round robin, free from the last beat read of the current cell
	//==========================================================================
	always_comb begin
		logic [PW-1:0] idx;
		gnt_valid = 1'b0;
		gnt_port  = rr_ptr;
		for (int i = 0; i < NP; i++) begin
			idx = rr_ptr + PW'(i);
			if (!gnt_valid && ready[idx] && (!rd_busy || rd_idx == '1)) begin
				gnt_valid = 1'b1;
				gnt_port  = idx;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (gnt_valid) begin
			rd_cell  <= q_head[gnt_port].addr;
			rd_first <= q_head[gnt_port].first;
			rd_last  <= q_head[gnt_port].last;
			rd_port  <= NP'(1) << gnt_port;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			rr_ptr      <= '0;
			rd_busy     <= 1'b0;
			rd_idx      <= '0;
			o_out_valid <= 1'b0;
			o_out_port  <= '0;
			out_first   <= 1'b0;
			out_last    <= 1'b0;
		end else begin
			if (gnt_valid) begin
				rr_ptr  <= gnt_port + 1'b1; // skip past the winner
				rd_busy <= 1'b1;
				rd_idx  <= '0;
			end else if (rd_busy) begin
				rd_idx <= rd_idx + 1'b1;
				if (rd_idx == '1)
					rd_busy <= 1'b0;
			end
			// flags lined up with ram data
			o_out_valid <= rd_busy;
			o_out_port  <= rd_busy ? rd_port : '0;
			out_first   <= rd_busy && rd_first && (rd_idx == '0);
			out_last    <= rd_busy && rd_last && (rd_idx == '1);
		end
	end

	assign o_rd_en        = rd_busy;
	assign o_rd_addr      = {rd_cell, rd_idx};
	assign o_release      = rd_busy && (rd_idx == '1); // one per copy
	assign o_release_addr = rd_cell;
	assign o_out_beat     = '{data: i_rd_data, first: out_first, last: out_last};

endmodule

`default_nettype wire

//--- rtl/switch_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module switch_core_top #(
	parameter int DATA_W        = 128,
	parameter int IN_FIFO_BEATS = 64,
	parameter int OUT_CREDITS   = 8
) (
	input  wire                              clk,
	input  wire                              rstn,
	input  wire                              i_desc_valid,
	input  wire swc_pkg::swc_desc_t          i_desc,
	input  wire                              i_beat_valid,
	input  wire [DATA_W-1:0]                 i_beat_data,
	output logic                             o_in_credit,
	output logic                             o_desc_credit,
	output logic                             o_out_valid,
	output logic [swc_pkg::NUM_PORTS-1:0]    o_out_port,
	output swc_pkg::swc_out_beat_t           o_out_beat,
	input  wire [swc_pkg::NUM_PORTS-1:0]     i_out_credit
);

	localparam int AW    = swc_pkg::CELL_AW + swc_pkg::BEAT_IDX_W;
	localparam int OUT_W = swc_pkg::MAX_DATA_W;

	logic                            alloc_req;
	logic [swc_pkg::CELL_AW-1:0]     alloc_addr;
	logic [swc_pkg::CELL_AW:0]       free_count;
	logic                            fq_ready;
	logic                            wr_en;
	logic [AW-1:0]                   wr_addr;
	logic [DATA_W-1:0]               wr_data;
	logic                            ref_wr;
	logic [swc_pkg::REF_W-1:0]       ref_count;
	logic [swc_pkg::NUM_PORTS-1:0]   enq;
	swc_pkg::swc_cell_ptr_t          enq_ptr;
	logic                            enq_block;
	logic                            rd_en;
	logic [AW-1:0]                   rd_addr;
	logic [DATA_W-1:0]               rd_data;
	logic [OUT_W-1:0]                rd_data_out;
	logic                            cell_release;
	logic [swc_pkg::CELL_AW-1:0]     release_addr;

	assign rd_data_out = OUT_W'(rd_data);

	swc_ingress_writer #(.DATA_W(DATA_W), .IN_FIFO_BEATS(IN_FIFO_BEATS)) u_ingress (
		.clk          (clk),
		.rstn         (rstn),
		.i_desc_valid (i_desc_valid),
		.i_desc       (i_desc),
		.i_beat_valid (i_beat_valid),
		.i_beat_data  (i_beat_data),
		.o_in_credit  (o_in_credit),
		.o_desc_credit(o_desc_credit),
		.o_alloc_req  (alloc_req),
		.i_alloc_addr (alloc_addr),
		.i_free_count (free_count),
		.i_fq_ready   (fq_ready),
		.o_wr_en      (wr_en),
		.o_wr_addr    (wr_addr),
		.o_wr_data    (wr_data),
		.o_ref_wr     (ref_wr),
		.o_ref_count  (ref_count),
		.o_enq        (enq),
		.o_enq_ptr    (enq_ptr),
		.i_enq_block  (enq_block)
	);

	swc_cell_buffer #(.DATA_W(DATA_W)) u_cell_buffer (
		.clk           (clk),
		.rstn          (rstn),
		.i_alloc_req   (alloc_req),
		.o_alloc_addr  (alloc_addr),
		.o_free_count  (free_count),
		.o_fq_ready    (fq_ready),
		.i_wr_en       (wr_en),
		.i_wr_addr     (wr_addr),
		.i_wr_data     (wr_data),
		.i_ref_wr      (ref_wr),
		.i_ref_count   (ref_count),
		.i_rd_en       (rd_en),
		.i_rd_addr     (rd_addr),
		.o_rd_data     (rd_data),
		.i_release     (cell_release),
		.i_release_addr(release_addr)
	);

	swc_egress_scheduler #(.OUT_CREDITS(OUT_CREDITS)) u_egress (
		.clk           (clk),
		.rstn          (rstn),
		.i_enq         (enq),
		.i_enq_ptr     (enq_ptr),
		.o_enq_block   (enq_block),
		.o_rd_en       (rd_en),
		.o_rd_addr     (rd_addr),
		.i_rd_data     (rd_data_out),
		.o_release     (cell_release),
		.o_release_addr(release_addr),
		.o_out_valid   (o_out_valid),
		.o_out_port    (o_out_port),
		.o_out_beat    (o_out_beat),
		.i_out_credit  (i_out_credit)
	);

endmodule

`default_nettype wire

//--- verif/switch_core_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module switch_core_asserts #(
	parameter int CW = 4
) (
	input wire                                        clk,
	input wire                                        rstn,
	input wire                                        i_gnt_valid,
	input wire [$clog2(swc_pkg::NUM_PORTS)-1:0]       i_gnt_port,
	input wire [swc_pkg::NUM_PORTS-1:0][CW-1:0]       i_credit,
	input wire                                        i_out_valid,
	input wire [swc_pkg::NUM_PORTS-1:0]               i_out_port
);

	// a full cell of credit before any grant
	grant_has_credits: assert property (@(posedge clk) disable iff (!rstn)
		i_gnt_valid |-> (i_credit[i_gnt_port] >= CW'(swc_pkg::BEATS_PER_CELL)))
		else $error("grant issued with fewer credits than one cell");

	out_port_onehot: assert property (@(posedge clk) disable iff (!rstn)
		i_out_valid |-> $onehot(i_out_port))
		else $error("output port mask not one-hot on a valid beat");

endmodule

bind swc_egress_scheduler switch_core_asserts #(.CW(CW)) u_asserts (
	.clk        (clk),
	.rstn       (rstn),
	.i_gnt_valid(gnt_valid),
	.i_gnt_port (gnt_port),
	.i_credit   (credit),
	.i_out_valid(o_out_valid),
	.i_out_port (o_out_port)
);

`default_nettype wire

//--- verif/tb_switch_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_switch_core;

	localparam int NP              = swc_pkg::NUM_PORTS;
	localparam int BPC             = swc_pkg::BEATS_PER_CELL;
	localparam int DATA_W          = 128;
	localparam int IN_FIFO_BEATS   = 64;
	localparam int OUT_CREDITS     = 8;
	localparam int DESC_CREDITS    = 8;
	localparam int TOTAL_CELLS     = 600;
	localparam int WATCHDOG_CYCLES = TOTAL_CELLS * BPC * 40 + 2000;

	logic                    clk;
	logic                    rstn;
	logic                    i_desc_valid;
	swc_pkg::swc_desc_t      i_desc;
	logic                    i_beat_valid;
	logic [DATA_W-1:0]       i_beat_data;
	logic                    o_in_credit;
	logic                    o_desc_credit;
	logic                    o_out_valid;
	logic [NP-1:0]           o_out_port;
	swc_pkg::swc_out_beat_t  o_out_beat;
	logic [NP-1:0]           i_out_credit = '0;

	logic [31:0]             lcg_state = 32'd69389;
	swc_pkg::swc_desc_t      desc_list [$];
	logic [DATA_W-1:0]       beat_list [$];
	swc_pkg::swc_out_beat_t  exp_q [NP][$];  // per-port expected beats
	int                      credit_due [NP][$];
	int                      last_due [NP];
	int                      sink_credit [NP];
	int                      rx_count [NP];
	int                      in_ret    = 0;
	int                      desc_ret  = 0;
	int                      cycle     = 0;

	switch_core_top #(
		.DATA_W       (DATA_W),
		.IN_FIFO_BEATS(IN_FIFO_BEATS),
		.OUT_CREDITS  (OUT_CREDITS)
	) switch_core_top_inst (
		.clk          (clk),
		.rstn         (rstn),
		.i_desc_valid (i_desc_valid),
		.i_desc       (i_desc),
		.i_beat_valid (i_beat_valid),
		.i_beat_data  (i_beat_data),
		.o_in_credit  (o_in_credit),
		.o_desc_credit(o_desc_credit),
		.o_out_valid  (o_out_valid),
		.o_out_port   (o_out_port),
		.o_out_beat   (o_out_beat),
		.i_out_credit (i_out_credit)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic stop_on_failure();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_beat(input string name, input swc_pkg::swc_out_beat_t expected,
	                          input swc_pkg::swc_out_beat_t actual);
		if (expected !== actual) begin
			$display("error %s: expected %h actual %h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("error %s: expected %0d actual %0d", name, expected, actual);
			stop_on_failure();
		end
	endtask

	//==========================================================================
	// traffic and reference model, built before reset
	//==========================================================================
	task automatic build_traffic();
		int                     cells_made;
		int                     ncells;
		logic [NP-1:0]          port_map;
		logic [DATA_W-1:0]      data;
		swc_pkg::swc_desc_t     desc;
		swc_pkg::swc_out_beat_t beat;
		cells_made = 0;
		while (cells_made < TOTAL_CELLS) begin
			port_map = NP'(1 + (next_rand() >> 16) % 15); // never zero
			ncells   = int'(1 + (next_rand() >> 16) % 6);
			if (ncells > TOTAL_CELLS - cells_made)
				ncells = TOTAL_CELLS - cells_made;
			desc.port_map   = port_map;
			desc.cell_count = 6'(ncells);
			desc_list.push_back(desc);
			for (int c = 0; c < ncells; c++) begin
				for (int b = 0; b < BPC; b++) begin
					data = {next_rand(), next_rand(), next_rand(), next_rand()};
					beat_list.push_back(data);
					beat = '{data: data, first: (c == 0 && b == 0),
					         last: (c == ncells - 1 && b == BPC - 1)};
					for (int p = 0; p < NP; p++) begin
						if (port_map[p])
							exp_q[p].push_back(beat);
					end
				end
			end
			cells_made += ncells;
		end
	endtask

	//==========================================================================
	// sinks: watch outputs mid-cycle, hand credits back later
	//==========================================================================
	task automatic observe_outputs();
		swc_pkg::swc_out_beat_t exp_beat;
		int                     due;
		if (o_in_credit)
			in_ret++;
		if (o_desc_credit)
			desc_ret++;
		for (int p = 0; p < NP; p++) begin
			if (o_out_valid && o_out_port[p]) begin
				if (sink_credit[p] == 0) begin
					$display("port %0d received a beat with no credit outstanding", p);
					stop_on_failure();
				end
				if (exp_q[p].size() == 0) begin
					$display("port %0d received a beat that no frame sent to it", p);
					stop_on_failure();
				end
				exp_beat = exp_q[p].pop_front();
				check_beat($sformatf("port %0d beat %0d", p, rx_count[p]), exp_beat, o_out_beat);
				rx_count[p]++;
				sink_credit[p]--;
				due = cycle + int'((next_rand() >> 16) % 6); // 0 to 5 cycles
				if (due <= last_due[p])
					due = last_due[p] + 1;  // one pulse per cycle
				last_due[p] = due;
				credit_due[p].push_back(due);
			end
		end
	endtask

	task automatic drive_credits();
		logic [NP-1:0] pulse;
		pulse = '0;
		for (int p = 0; p < NP; p++) begin
			if (credit_due[p].size() > 0 && credit_due[p][0] <= cycle) begin
				pulse[p] = 1'b1;
				void'(credit_due[p].pop_front());
				sink_credit[p]++;
			end
		end
		i_out_credit = pulse;
	endtask

	initial begin
		for (int p = 0; p < NP; p++) begin
			sink_credit[p] = OUT_CREDITS;
			last_due[p]    = 0;
			rx_count[p]    = 0;
		end
		forever begin
			@(posedge clk);
			cycle++;
			#1;
			drive_credits();
			@(negedge clk);
			if (rstn)
				observe_outputs();
		end
	end

	function automatic bit all_drained();
		for (int p = 0; p < NP; p++)
			if (exp_q[p].size() != 0)
				return 1'b0;
		return 1'b1;
	endfunction

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired before the traffic drained");
		stop_on_failure();
	end

	//==========================================================================
	// source side, honours beat and descriptor credits
	//==========================================================================
	initial begin
		int d_idx;
		int b_idx;
		rstn         = 1'b0;
		i_desc_valid = 1'b0;
		i_desc       = '0;
		i_beat_valid = 1'b0;
		i_beat_data  = '0;
		d_idx        = 0;
		b_idx        = 0;
		build_traffic();
		repeat (4) @(posedge clk);
		#1 rstn = 1'b1;
		while (d_idx < desc_list.size() || b_idx < beat_list.size()) begin
			@(posedge clk);
			#1;
			i_desc_valid = 1'b0;
			i_beat_valid = 1'b0;
			if (d_idx < desc_list.size() && d_idx - desc_ret < DESC_CREDITS) begin
				i_desc       = desc_list[d_idx];
				i_desc_valid = 1'b1;
				d_idx++;
			end
			if (b_idx < beat_list.size() && b_idx - in_ret < IN_FIFO_BEATS) begin
				i_beat_data  = beat_list[b_idx];
				i_beat_valid = 1'b1;
				b_idx++;
			end
		end
		@(posedge clk);
		#1;
		i_desc_valid = 1'b0;
		i_beat_valid = 1'b0;
		while (!all_drained())
			@(negedge clk);
		repeat (50) @(posedge clk); // catch any late stray beats
		check_count("input credits", beat_list.size(), in_ret);
		check_count("descriptor credits", desc_list.size(), desc_ret);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
rtl/swc_pkg.sv
rtl/swc_sync_fifo.sv
rtl/swc_free_queue.sv
rtl/swc_cell_buffer.sv
rtl/swc_ingress_writer.sv
rtl/swc_egress_scheduler.sv
rtl/switch_core_top.sv
verif/switch_core_asserts.sv
verif/tb_switch_core.sv

//--- run.sh
#!/bin/sh
# build and run the switch core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_switch_core \
	-f list.f -Mdir obj_dir -o sim_switch_core; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_switch_core)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
	exit 0
fi
exit 1
